// ==== evcap_pkg.sv ====
package evcap_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // event record format

   // field widths inside one 32-bit record
   localparam int SRC_W = 7;
   localparam int TS_W  = 24;

   // free-running cycle count, latched when a group is loaded
   typedef logic [TS_W-1:0] timestamp_t;

   // source number of one event line
   typedef logic [SRC_W-1:0] src_idx_t;

   // drop and overflow counters, both stick at all ones
   typedef logic [15:0] count_t;

   // one stored record
   // valid is bit 31 and is always set once a record is in the buffer
   typedef struct packed {
      logic       valid;
      src_idx_t   src;
      timestamp_t ts;
   } event_record_t;

   ////////////////////////////////////////////////////////////////////////////
   // register map, byte offsets

   localparam logic [7:0] REG_CTRL   = 8'h00;
   localparam logic [7:0] REG_STATUS = 8'h04;
   localparam logic [7:0] REG_EVENT  = 8'h08;
   localparam logic [7:0] REG_DROPS  = 8'h0C;

endpackage

// ==== axil_pkg.sv ====
package axil_pkg;

   // bus widths
   typedef logic [7:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;

   // response codes on bresp and rresp
   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

   // master side, write address, write data, write response, read channels
   typedef struct packed {
      logic       awvalid;
      axil_addr_t awaddr;
      logic       wvalid;
      axil_data_t wdata;
      logic       bready;
      logic       arvalid;
      axil_addr_t araddr;
      logic       rready;
   } axil_req_t;

   // slave side
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      axil_resp_t bresp;
      logic       arready;
      logic       rvalid;
      axil_data_t rdata;
      axil_resp_t rresp;
   } axil_rsp_t;

endpackage

// ==== entry_packer.sv ====
`timescale 1ns/1ps

module entry_packer #(
   parameter int NUM_SOURCES = 8
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic [NUM_SOURCES-1:0]                   valid_entries,
   output logic [NUM_SOURCES*evcap_pkg::SRC_W-1:0]  ordered,
   output logic [$clog2(NUM_SOURCES+1)-1:0]         num_valid
);

   import evcap_pkg::*;

   localparam int LIST_W = NUM_SOURCES * SRC_W;
   localparam int CNT_W  = $clog2(NUM_SOURCES + 1);

   typedef logic [LIST_W-1:0] list_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   // below[i] counts the valid entries under entry i
   // below[NUM_SOURCES] ends up as the total
   cnt_t  below  [NUM_SOURCES+1];
   list_t placed [NUM_SOURCES];
   list_t ored   [NUM_SOURCES+1];

   assign below[0] = '0;
   assign ored[0]  = '0;

   for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_pack
      assign below[i+1] = below[i] + cnt_t'(valid_entries[i]);
      // drop the entry number into the field after the ones already placed
      assign placed[i] = valid_entries[i] ? (list_t'(i) << (below[i] * SRC_W)) : '0;
      // invalid entries contribute zero so a plain OR merges the list
      assign ored[i+1] = ored[i] | placed[i];
   end

   // one register stage, new list every cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         ordered   <= '0;
         num_valid <= '0;
      end else begin
         ordered   <= ored[NUM_SOURCES];
         num_valid <= below[NUM_SOURCES];
      end
   end

endmodule

// ==== event_serializer.sv ====
`timescale 1ns/1ps

module event_serializer #(
   parameter int NUM_SOURCES = 8
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     enable,
   input  logic [NUM_SOURCES*evcap_pkg::SRC_W-1:0]  ordered,
   input  logic [$clog2(NUM_SOURCES+1)-1:0]         num_valid,
   output logic                                     wr_req,
   output evcap_pkg::event_record_t                 wr_record,
   input  logic                                     wr_gnt,
   output evcap_pkg::count_t                        drops
);

   import evcap_pkg::*;

   localparam int LIST_W = NUM_SOURCES * SRC_W;
   localparam int CNT_W  = $clog2(NUM_SOURCES + 1);
   localparam int IDX_W  = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1;

   typedef enum logic {idle, emit} state_t;

   state_t            state;
   logic [LIST_W-1:0] list_q;
   logic [CNT_W-1:0]  remaining;
   logic [IDX_W-1:0]  idx;
   timestamp_t        ts_cnt;
   timestamp_t        ts_q;
   logic              group_in;

   // a nonempty group seen while capture is on
   assign group_in = enable && (num_valid != '0);

   // request stays up for the whole emit phase, one record per grant
   assign wr_req           = (state == emit);
   assign wr_record.valid  = 1'b1;
   assign wr_record.src    = list_q[idx*SRC_W +: SRC_W];
   assign wr_record.ts     = ts_q;

   ////////////////////////////////////////////////////////////////////////////
   // control

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= idle;
         remaining <= '0;
         idx       <= '0;
         ts_cnt    <= '0;
         drops     <= '0;
      end else begin
         // timestamp runs every cycle and simply wraps
         ts_cnt <= ts_cnt + 1'b1;
         case (state)
            idle: begin
               if (group_in) begin
                  state     <= emit;
                  remaining <= num_valid;
                  idx       <= '0;
               end
            end
            emit: begin
               // busy, a new group is lost whole
               if (group_in && (drops != '1))
                  drops <= drops + 1'b1;
               if (wr_gnt) begin
                  // last grant frees the serializer
                  if (remaining == CNT_W'(1))
                     state <= idle;
                  remaining <= remaining - 1'b1;
                  idx       <= idx + 1'b1;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // group payload and its timestamp, taken on load
   always_ff @(posedge clk) begin
      if ((state == idle) && group_in) begin
         list_q <= ordered;
         ts_q   <= ts_cnt;
      end
   end

endmodule

// ==== event_buffer_arbiter.sv ====
`timescale 1ns/1ps

module event_buffer_arbiter #(
   parameter int BUF_DEPTH = 16
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wr_req,
   input  evcap_pkg::event_record_t  wr_record,
   output logic                      wr_gnt,
   input  logic                      rd_req,
   output logic                      rd_gnt,
   output evcap_pkg::event_record_t  rd_data,
   output logic                      rd_empty,
   output logic [15:0]               fill,
   output evcap_pkg::count_t         overflows
);

   import evcap_pkg::*;

   localparam int PTR_W = $clog2(BUF_DEPTH);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [PTR_W:0]   occ_t;

   event_record_t mem [BUF_DEPTH];
   ptr_t          head;
   ptr_t          tail;
   occ_t          occ;
   logic          prio_rd;
   logic          full;
   logic          empty;
   logic          push;
   logic          pop;

   ////////////////////////////////////////////////////////////////////////////
   // arbitration

   // lone requester wins at once
   // on a collision the priority bit picks, then flips
   assign wr_gnt = wr_req && (!rd_req || !prio_rd);
   assign rd_gnt = rd_req && (!wr_req || prio_rd);

   assign full  = (occ == occ_t'(BUF_DEPTH));
   assign empty = (occ == '0);

   // granted requests that really move data
   assign push = wr_gnt && !full;
   assign pop  = rd_gnt && !empty;

   assign fill = 16'(occ);

   ////////////////////////////////////////////////////////////////////////////
   // ring buffer pointers and counters

   always_ff @(posedge clk) begin
      if (reset) begin
         prio_rd   <= 1'b0;
         head      <= '0;
         tail      <= '0;
         occ       <= '0;
         rd_empty  <= 1'b1;
         overflows <= '0;
      end else begin
         if (wr_req && rd_req)
            prio_rd <= ~prio_rd;
         if (push)
            tail <= tail + 1'b1;
         if (pop)
            head <= head + 1'b1;
         // only one grant per cycle so push and pop never meet
         if (push)
            occ <= occ + 1'b1;
         else if (pop)
            occ <= occ - 1'b1;
         // granted write into a full buffer is thrown away
         if (wr_gnt && full && (overflows != '1))
            overflows <= overflows + 1'b1;
         if (rd_gnt)
            rd_empty <= empty;
      end
   end

   // memory port, read data lands the cycle after the grant
   always_ff @(posedge clk) begin
      if (push)
         mem[tail] <= wr_record;
      if (rd_gnt)
         rd_data <= empty ? '0 : mem[head];
   end

endmodule

// ==== evcap_axil_regs.sv ====
`timescale 1ns/1ps

module evcap_axil_regs (
   input  logic                      clk,
   input  logic                      reset,
   input  axil_pkg::axil_req_t       s_axil_req,
   output axil_pkg::axil_rsp_t       s_axil_rsp,
   output logic                      enable,
   output logic                      rd_req,
   input  logic                      rd_gnt,
   input  evcap_pkg::event_record_t  rd_data,
   input  logic                      rd_empty,
   input  logic [15:0]               fill,
   input  evcap_pkg::count_t         drops,
   input  evcap_pkg::count_t         overflows
);

   import axil_pkg::*;
   import evcap_pkg::*;

   typedef enum logic [1:0] {w_idle, w_ack, w_resp} wr_state_t;
   typedef enum logic [2:0] {r_idle, r_ack, r_pop, r_data, r_resp} rd_state_t;

   wr_state_t  wr_state;
   rd_state_t  rd_state;
   axil_resp_t bresp;
   axil_resp_t rresp;
   axil_data_t rdata;

   // handshake outputs come straight from the channel states
   assign s_axil_rsp.awready = (wr_state == w_ack);
   assign s_axil_rsp.wready  = (wr_state == w_ack);
   assign s_axil_rsp.bvalid  = (wr_state == w_resp);
   assign s_axil_rsp.bresp   = bresp;
   assign s_axil_rsp.arready = (rd_state == r_ack);
   assign s_axil_rsp.rvalid  = (rd_state == r_resp);
   assign s_axil_rsp.rdata   = rdata;
   assign s_axil_rsp.rresp   = rresp;

   // pop request held until the arbiter grants
   assign rd_req = (rd_state == r_pop);

   ////////////////////////////////////////////////////////////////////////////
   // write and read channel FSMs

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_state <= w_idle;
         rd_state <= r_idle;
         enable   <= 1'b0;
      end else begin
         case (wr_state)
            // wait for address and data together
            w_idle: if (s_axil_req.awvalid && s_axil_req.wvalid) wr_state <= w_ack;
            w_ack: begin
               // only the control register is writable
               if (s_axil_req.awaddr == REG_CTRL)
                  enable <= s_axil_req.wdata[0];
               wr_state <= w_resp;
            end
            w_resp: if (s_axil_req.bready) wr_state <= w_idle;
            default: wr_state <= w_idle;
         endcase
         case (rd_state)
            r_idle: if (s_axil_req.arvalid) rd_state <= r_ack;
            // event reads go through the arbiter, the rest answer next cycle
            r_ack:  rd_state <= (s_axil_req.araddr == REG_EVENT) ? r_pop : r_resp;
            r_pop:  if (rd_gnt) rd_state <= r_data;
            r_data: rd_state <= r_resp;
            r_resp: if (s_axil_req.rready) rd_state <= r_idle;
            default: rd_state <= r_idle;
         endcase
      end
   end

   // response payload
   always_ff @(posedge clk) begin
      if (wr_state == w_ack)
         bresp <= (s_axil_req.awaddr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
      if (rd_state == r_ack) begin
         rresp <= RESP_OKAY;
         case (s_axil_req.araddr)
            REG_CTRL:   rdata <= {31'b0, enable};
            REG_STATUS: rdata <= {overflows, fill};
            REG_EVENT:  rdata <= '0;
            REG_DROPS:  rdata <= {16'b0, drops};
            default: begin
               rdata <= '0;
               rresp <= RESP_SLVERR;
            end
         endcase
      end
      // popped record, zeros when the buffer was empty
      if (rd_state == r_data)
         rdata <= rd_empty ? '0 : rd_data;
   end

endmodule

// ==== event_capture_top.sv ====
`timescale 1ns/1ps

module event_capture_top #(
   parameter int NUM_SOURCES = 8,
   parameter int BUF_DEPTH   = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [NUM_SOURCES-1:0] events,
   input  axil_pkg::axil_req_t    s_axil_req,
   output axil_pkg::axil_rsp_t    s_axil_rsp
);

   import evcap_pkg::*;

   logic [NUM_SOURCES*SRC_W-1:0]     ordered;
   logic [$clog2(NUM_SOURCES+1)-1:0] num_valid;
   logic                             enable;
   logic                             wr_req;
   logic                             wr_gnt;
   logic                             rd_req;
   logic                             rd_gnt;
   logic                             rd_empty;
   event_record_t                    wr_record;
   event_record_t                    rd_data;
   logic [15:0]                      fill;
   count_t                           drops;
   count_t                           overflows;

   // event lines into ordered source lists
   entry_packer #(.NUM_SOURCES(NUM_SOURCES)) packer_i (
      .clk(clk), .reset(reset), .valid_entries(events),
      .ordered(ordered), .num_valid(num_valid)
   );

   // one record request per listed source
   event_serializer #(.NUM_SOURCES(NUM_SOURCES)) serializer_i (
      .clk(clk), .reset(reset), .enable(enable),
      .ordered(ordered), .num_valid(num_valid),
      .wr_req(wr_req), .wr_record(wr_record), .wr_gnt(wr_gnt), .drops(drops)
   );

   // shared ring buffer
   event_buffer_arbiter #(.BUF_DEPTH(BUF_DEPTH)) arbiter_i (
      .clk(clk), .reset(reset),
      .wr_req(wr_req), .wr_record(wr_record), .wr_gnt(wr_gnt),
      .rd_req(rd_req), .rd_gnt(rd_gnt), .rd_data(rd_data), .rd_empty(rd_empty),
      .fill(fill), .overflows(overflows)
   );

   // software view
   evcap_axil_regs regs_i (
      .clk(clk), .reset(reset),
      .s_axil_req(s_axil_req), .s_axil_rsp(s_axil_rsp), .enable(enable),
      .rd_req(rd_req), .rd_gnt(rd_gnt), .rd_data(rd_data), .rd_empty(rd_empty),
      .fill(fill), .drops(drops), .overflows(overflows)
   );

endmodule

// ==== tb_event_capture.sv ====
`timescale 1ns/1ps

module tb_event_capture;

   import axil_pkg::*;
   import evcap_pkg::*;

   localparam int NUM_SOURCES = 8;
   localparam int BUF_DEPTH   = 16;
   localparam int TIMEOUT     = 200;
   localparam int NUM_ROWS    = 8;

   // stimulus row with its event vector, the idle cycles after it and the recorded flag
   typedef struct packed {
      logic [NUM_SOURCES-1:0] ev;
      logic [7:0]             gap;
      logic                   recorded;
   } row_t;

   logic                   clk;
   logic                   reset;
   logic [NUM_SOURCES-1:0] events;
   axil_req_t              s_axil_req;
   axil_rsp_t              s_axil_rsp;

   row_t       rows [NUM_ROWS];
   integer     seed;
   logic [31:0] rand_word;
   int         errors;
   int         reads;
   int         last_ts;
   logic       enabled;
   axil_data_t rd_val;
   axil_resp_t resp;

   event_capture_top #(.NUM_SOURCES(NUM_SOURCES), .BUF_DEPTH(BUF_DEPTH)) dut_i (
      .clk(clk), .reset(reset), .events(events),
      .s_axil_req(s_axil_req), .s_axil_rsp(s_axil_rsp)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // reporting and bus helpers

   task automatic mismatch(input string what, input longint got, input longint exp);
      errors++;
      $display("[FAIL] %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
   endtask

   task automatic give_up(input string what);
      $display("timeout: the DUT never raised %s within %0d cycles", what, TIMEOUT);
      $display("%0d bus reads, %0d errors", reads, errors + 1);
      $display("Test FAILED");
      $finish;
   endtask

   // slave flag picked by number
   // 0 selects awready with wready, 1 bvalid, 2 arready and 3 rvalid
   function automatic logic rsp_flag(input int sel);
      case (sel)
         0: return s_axil_rsp.awready && s_axil_rsp.wready;
         1: return s_axil_rsp.bvalid;
         2: return s_axil_rsp.arready;
         default: return s_axil_rsp.rvalid;
      endcase
   endfunction

   // sampled at falling edges away from the DUT's register updates
   task automatic wait_flag(input int sel, input string what);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (rsp_flag(sel) !== 1'b1 && n < TIMEOUT);
      if (rsp_flag(sel) !== 1'b1)
         give_up(what);
   endtask

   task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t bresp_out);
      @(posedge clk);
      #1;
      s_axil_req.awaddr  = addr;
      s_axil_req.wdata   = data;
      s_axil_req.awvalid = 1'b1;
      s_axil_req.wvalid  = 1'b1;
      wait_flag(0, "awready and wready");
      // address and data go at the next rising edge
      @(posedge clk);
      #1;
      s_axil_req.awvalid = 1'b0;
      s_axil_req.wvalid  = 1'b0;
      s_axil_req.bready  = 1'b1;
      wait_flag(1, "bvalid");
      bresp_out = s_axil_rsp.bresp;
      @(posedge clk);
      #1;
      s_axil_req.bready = 1'b0;
   endtask

   task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t rresp_out);
      reads++;
      @(posedge clk);
      #1;
      s_axil_req.araddr  = addr;
      s_axil_req.arvalid = 1'b1;
      wait_flag(2, "arready");
      @(posedge clk);
      #1;
      s_axil_req.arvalid = 1'b0;
      s_axil_req.rready  = 1'b1;
      // event pops take a variable number of cycles
      wait_flag(3, "rvalid");
      data      = s_axil_rsp.rdata;
      rresp_out = s_axil_rsp.rresp;
      @(posedge clk);
      #1;
      s_axil_req.rready = 1'b0;
   endtask

   task automatic check_reg(input axil_addr_t addr, input axil_data_t exp, input string what);
      read_reg(addr, rd_val, resp);
      if (rd_val !== exp)
         mismatch(what, rd_val, exp);
      if (resp !== RESP_OKAY)
         mismatch({what, " response"}, resp, RESP_OKAY);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // event stimulus and record checks

   // one cycle pulse on the event lines followed by gap idle cycles
   task automatic apply_group(input logic [NUM_SOURCES-1:0] ev, input int gap);
      @(posedge clk);
      #1;
      events = ev;
      @(posedge clk);
      #1;
      events = '0;
      repeat (gap) @(posedge clk);
   endtask

   // pops one group with sources in ascending bit order of ev
   // at most max_n records are taken
   task automatic expect_records(input logic [NUM_SOURCES-1:0] ev, input int max_n);
      event_record_t rec;
      int            n;
      int            group_ts;
      n = 0;
      group_ts = -1;
      for (int i = 0; i < NUM_SOURCES; i++) begin
         if (ev[i] && n < max_n) begin
            read_reg(REG_EVENT, rd_val, resp);
            rec = event_record_t'(rd_val);
            if (resp !== RESP_OKAY)
               mismatch("record response", resp, RESP_OKAY);
            if (rec.valid !== 1'b1)
               mismatch("record valid bit", rec.valid, 1);
            if (rec.src !== src_idx_t'(i))
               mismatch("record source", rec.src, i);
            // the first record sets the group timestamp
            if (n == 0)
               group_ts = int'(rec.ts);
            else if (int'(rec.ts) != group_ts)
               mismatch("timestamp inside a group", rec.ts, group_ts);
            n++;
         end
      end
      if (group_ts <= last_ts)
         mismatch("timestamp not above the previous group", group_ts, last_ts);
      last_ts = group_ts;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      events     = '0;
      s_axil_req = '0;
      errors     = 0;
      reads      = 0;
      last_ts    = -1;
      enabled    = 1'b0;
      seed       = 32'h428e216c;

      // fixed rows first with row 3 applied while capture is off
      rows[0] = '{8'h01, 8'd14, 1'b1};
      rows[1] = '{8'h81, 8'd12, 1'b1};
      rows[2] = '{8'hFF, 8'd16, 1'b1};
      rows[3] = '{8'h3C, 8'd12, 1'b0};
      rows[4] = '{8'h92, 8'd12, 1'b1};
      // random rows are never empty and row 6 runs with capture off
      for (int r = 5; r < NUM_ROWS; r++) begin
         rand_word = $random(seed);
         rows[r].ev = rand_word[NUM_SOURCES-1:0];
         if (rows[r].ev == '0)
            rows[r].ev = 8'h10;
         rows[r].gap = 8'd14;
         rows[r].recorded = (r != 6);
      end

      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      // reset values
      check_reg(REG_CTRL, 32'h0, "CTRL after reset");
      check_reg(REG_STATUS, 32'h0, "STATUS after reset");
      check_reg(REG_DROPS, 32'h0, "DROPS after reset");
      check_reg(REG_EVENT, 32'h0, "pop of the empty buffer");

      // capture is switched to match each row's flag
      for (int r = 0; r < NUM_ROWS; r++) begin
         if (rows[r].recorded != enabled) begin
            write_reg(REG_CTRL, {31'b0, rows[r].recorded}, resp);
            if (resp !== RESP_OKAY)
               mismatch("CTRL write response", resp, RESP_OKAY);
            enabled = rows[r].recorded;
         end
         apply_group(rows[r].ev, rows[r].gap);
         if (rows[r].recorded) begin
            expect_records(rows[r].ev, NUM_SOURCES);
         end else begin
            check_reg(REG_STATUS, 32'h0, "STATUS after a disabled group");
            check_reg(REG_DROPS, 32'h0, "DROPS after a disabled group");
         end
      end

      write_reg(REG_CTRL, 32'h1, resp);

      // back to back groups where the second finds the serializer busy
      @(posedge clk);
      #1;
      events = 8'h24;
      @(posedge clk);
      #1;
      events = 8'h81;
      @(posedge clk);
      #1;
      events = '0;
      repeat (12) @(posedge clk);
      check_reg(REG_DROPS, 32'h1, "DROPS after back to back groups");
      expect_records(8'h24, NUM_SOURCES);
      check_reg(REG_EVENT, 32'h0, "pop after the kept group");

      // 20 records into the ring without popping
      apply_group(8'hFF, 16);
      apply_group(8'h5A, 16);
      apply_group(8'hFF, 16);
      check_reg(REG_STATUS, {16'(20 - BUF_DEPTH), 16'(BUF_DEPTH)}, "STATUS after overflow");
      expect_records(8'hFF, NUM_SOURCES);
      expect_records(8'h5A, NUM_SOURCES);
      expect_records(8'hFF, BUF_DEPTH - 12);
      check_reg(REG_EVENT, 32'h0, "pop after draining");

      // error responses
      write_reg(REG_DROPS, 32'h1, resp);
      if (resp !== RESP_SLVERR)
         mismatch("write to DROPS response", resp, RESP_SLVERR);
      read_reg(8'h10, rd_val, resp);
      if (resp !== RESP_SLVERR)
         mismatch("read of offset 0x10 response", resp, RESP_SLVERR);
      check_reg(REG_DROPS, 32'h1, "DROPS after the rejected write");

      $display("%0d bus reads, %0d errors", reads, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== build.f ====
evcap_pkg.sv
axil_pkg.sv
entry_packer.sv
event_serializer.sv
event_buffer_arbiter.sv
evcap_axil_regs.sv
event_capture_top.sv
tb_event_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the event capture testbench with Verilator and run it
# the log is searched for the testbench failure line
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_event_capture \
   -f build.f -o tb_event_capture > sim.log 2>&1 &&
   ./obj_dir/tb_event_capture >> sim.log 2>&1 ||
   { echo "Verilator build or simulation run failed, see sim.log"; exit 1; }

grep -q "Test FAILED" sim.log &&
   { echo "simulation reported errors, see sim.log"; exit 1; } ||
   { echo "simulation passed"; exit 0; }
